// File: vlog.f
hdl/game_view_pkg.sv
hdl/pixel_if.sv
hdl/object_table.sv
hdl/background_painter.sv
hdl/object_painter.sv
hdl/round_timer.sv
hdl/view_ctrl.sv
hdl/view_top.sv
tb/tb_clock.sv
tb/view_top_tb.sv

// File: Makefile
# Verilator build and run of the game view testbench

SRCS := $(wildcard hdl/*.sv tb/*.sv)

all: obj_dir/Vview_top_tb

# rebuilt only when a source or the file list changes
obj_dir/Vview_top_tb: vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module view_top_tb -o Vview_top_tb -f vlog.f

.PHONY: all run clean

run: obj_dir/Vview_top_tb
	./obj_dir/Vview_top_tb

clean:
	rm -rf obj_dir

// File: tb/view_top_tb.sv
/* directed testbench for the game view top level with reset state,
   background, sprite, level rule and game-over tests */
`timescale 1ns/10ps

module view_top_tb import game_view_pkg::*; ();

	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 24;
	localparam int GROUND_Y = 8;
	localparam int SPRITE_SIZE = 4;
	localparam int OBJ_COUNT = 4;
	localparam int TICKS_PER_SEC = 100;
	localparam int ROUND_SECONDS = 5;
	localparam int IDX_W = $clog2(OBJ_COUNT);
	localparam int BG_PIXELS = SCREEN_W * SCREEN_H;
	localparam int FRAME_TIMEOUT = 2000;
	localparam int ROUND_TIMEOUT = 1000;

	typedef struct packed {
		x_t x;
		y_t y;
		color_t color;
	} pix_t;

	logic clk;
	logic resetn;
	logic reset_req;
	logic go;
	score_t score;
	logic obj_wr;
	logic [IDX_W-1:0] obj_idx;
	obj_entry_t obj_data;
	x_t x;
	y_t y;
	color_t color;
	logic write_en;
	logic frame_done;
	level_t level;
	logic game_over;
	logic [7:0] time_left;

	integer seed = 32'h4858;
	pix_t pixels[$];
	// what the testbench has written into the object table
	obj_entry_t loaded [OBJ_COUNT];

	tb_clock clock_i (
		.reset_req(reset_req),
		.clk(clk),
		.resetn(resetn)
	);

	view_top #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.GROUND_Y(GROUND_Y),
		.SPRITE_SIZE(SPRITE_SIZE),
		.OBJ_COUNT(OBJ_COUNT),
		.TICKS_PER_SEC(TICKS_PER_SEC),
		.ROUND_SECONDS(ROUND_SECONDS)
	) dut_i (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.score(score),
		.obj_wr(obj_wr),
		.obj_idx(obj_idx),
		.obj_data(obj_data),
		.x(x),
		.y(y),
		.color(color),
		.write_en(write_en),
		.frame_done(frame_done),
		.level(level),
		.game_over(game_over),
		.time_left(time_left)
	);

	// pixel collector sampling the settled outputs at the falling edge
	always @(negedge clk) begin
		if (write_en)
			pixels.push_back(pix_t'({x, y, color}));
	end

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_pixel(input int n, input x_t ex, input y_t ey, input color_t ec);
		check_value($sformatf("x[%0d]", n), 32'(pixels[n].x), 32'(ex));
		check_value($sformatf("y[%0d]", n), 32'(pixels[n].y), 32'(ey));
		check_value($sformatf("color[%0d]", n), 32'(pixels[n].color), 32'(ec));
	endtask

	function automatic color_t kind_color(input obj_kind_t k);
		case (k)
			KIND_GOLD: return GOLD_COLOR;
			KIND_STONE: return STONE_COLOR;
			KIND_DIAMOND: return DIAMOND_COLOR;
			default: return '0;
		endcase
	endfunction

	function automatic logic is_drawable(input obj_entry_t e);
		return e.visible && (e.kind != KIND_NONE);
	endfunction

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!resetn) begin
			if (waited == 40)
				report_timeout("reset release");
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_req = 1'b1;
		go = 1'b0;
		obj_wr = 1'b0;
		@(negedge clk);
		reset_req = 1'b0;
		// the table comes back empty
		for (int i = 0; i < OBJ_COUNT; i++)
			loaded[i] = '0;
		wait_reset_release();
	endtask

	task automatic write_entry(input int idx, input obj_entry_t e);
		@(negedge clk);
		obj_wr = 1'b1;
		obj_idx = IDX_W'(idx);
		obj_data = e;
		@(negedge clk);
		obj_wr = 1'b0;
		loaded[idx] = e;
	endtask

	// one go pulse and collection until frame_done
	task automatic run_frame();
		int waited;
		pixels.delete();
		@(negedge clk);
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		waited = 0;
		while (!frame_done) begin
			if (waited == FRAME_TIMEOUT)
				report_timeout("frame_done");
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		check_value("frame_done", 32'(frame_done), 32'd0);
	endtask

	task automatic check_background(input logic over_fill);
		color_t exp_color;
		for (int yy = 0; yy < SCREEN_H; yy++) begin
			for (int xx = 0; xx < SCREEN_W; xx++) begin
				if (over_fill)
					exp_color = OVER_COLOR;
				else if (yy < GROUND_Y)
					exp_color = SKY_COLOR;
				else
					exp_color = EARTH_COLOR;
				check_pixel(yy * SCREEN_W + xx, x_t'(xx), y_t'(yy), exp_color);
			end
		end
	endtask

	task automatic after_reset();
		wait_reset_release();
		check_value("write_en", 32'(write_en), 32'd0);
		check_value("frame_done", 32'(frame_done), 32'd0);
		check_value("game_over", 32'(game_over), 32'd0);
		check_value("level", 32'(level), 32'd0);
		check_value("time_left", 32'(time_left), 32'(ROUND_SECONDS));
	endtask

	task automatic empty_frame();
		apply_reset();
		score = '0;
		run_frame();
		check_value("write count", 32'(pixels.size()), 32'(BG_PIXELS));
		check_background(1'b0);
	endtask

	task automatic object_frame();
		obj_entry_t e;
		int n;
		int drawn;
		apply_reset();
		score = '0;
		for (int i = 0; i < OBJ_COUNT; i++) begin
			e.x = x_t'($unsigned($random(seed)) % SCREEN_W);
			e.y = y_t'($unsigned($random(seed)) % SCREEN_H);
			e.kind = obj_kind_t'(2'($unsigned($random(seed)) % 4));
			e.visible = (i != 1);
			// at least one sprite is always drawn
			if (i == 0 && e.kind == KIND_NONE)
				e.kind = KIND_GOLD;
			// the hidden slot holds a real kind, so only its visible bit hides it
			if (i == 1 && e.kind == KIND_NONE)
				e.kind = KIND_STONE;
			write_entry(i, e);
		end
		run_frame();
		drawn = 0;
		for (int i = 0; i < OBJ_COUNT; i++)
			if (is_drawable(loaded[i]))
				drawn++;
		check_value("write count", 32'(pixels.size()),
			32'(BG_PIXELS + drawn * SPRITE_SIZE * SPRITE_SIZE));
		check_background(1'b0);
		n = BG_PIXELS;
		for (int i = 0; i < OBJ_COUNT; i++) begin
			if (is_drawable(loaded[i])) begin
				for (int dy = 0; dy < SPRITE_SIZE; dy++) begin
					for (int dx = 0; dx < SPRITE_SIZE; dx++) begin
						check_pixel(n, x_t'(loaded[i].x + dx), y_t'(loaded[i].y + dy),
							kind_color(loaded[i].kind));
						n++;
					end
				end
			end
		end
	endtask

	task automatic level_advance();
		apply_reset();
		score = score_t'($unsigned($random(seed)) % 75);
		run_frame();
		check_value("level", 32'(level), 32'd0);
		apply_reset();
		score = 10'd75;
		run_frame();
		check_value("level", 32'(level), 32'd1);
		// level-up reloads the round
		check_value("time_left", 32'(time_left), 32'(ROUND_SECONDS));
		check_value("game_over", 32'(game_over), 32'd0);
		// goal of level 1 is 150
		score = 10'd149;
		run_frame();
		check_value("level", 32'(level), 32'd1);
	endtask

	task automatic timeout_game_over();
		obj_entry_t e;
		int waited;
		apply_reset();
		score = '0;
		e.x = 9'd3;
		e.y = 8'd12;
		e.kind = KIND_DIAMOND;
		e.visible = 1'b1;
		write_entry(0, e);
		e.x = 9'd20;
		e.kind = KIND_STONE;
		write_entry(2, e);
		waited = 0;
		while (!(time_left == 8'd0 && game_over)) begin
			if (waited == ROUND_TIMEOUT)
				report_timeout("time-out and game over");
			@(negedge clk);
			waited++;
		end
		check_value("level", 32'(level), 32'd0);
		run_frame();
		check_value("write count", 32'(pixels.size()), 32'(BG_PIXELS));
		check_background(1'b1);
		check_value("game_over", 32'(game_over), 32'd1);
		check_value("level", 32'(level), 32'd0);
	endtask

	initial begin
		reset_req = 1'b0;
		go = 1'b0;
		score = '0;
		obj_wr = 1'b0;
		obj_idx = '0;
		obj_data = '0;
		for (int i = 0; i < OBJ_COUNT; i++)
			loaded[i] = '0;
		after_reset();
		empty_frame();
		object_frame();
		level_advance();
		timeout_game_over();
		$display("test passed");
		$finish;
	end

endmodule

// File: tb/tb_clock.sv
/* testbench clock, 20 ns period, and synchronous active-low reset */
`timescale 1ns/10ps

module tb_clock #(
	parameter int RESET_CYCLES = 8
) (
	input logic reset_req,
	output logic clk,
	output logic resetn
);

	logic rst_q = 1'b0;
	int cycles = 0;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// low for RESET_CYCLES rising edges, restarted by reset_req
	always @(posedge clk) begin
		if (reset_req) begin
			rst_q <= 1'b0;
			cycles <= 0;
		end else if (cycles < RESET_CYCLES - 1) begin
			cycles <= cycles + 1;
		end else begin
			rst_q <= 1'b1;
		end
	end

	assign resetn = rst_q;

endmodule

// File: hdl/view_top.sv
/* game view top level, controller, painters, object table and round timer */
`timescale 1ns/10ps

module view_top import game_view_pkg::*; #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int GROUND_Y = 80,
	parameter int SPRITE_SIZE = 20,
	parameter int OBJ_COUNT = 15,
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int ROUND_SECONDS = 60
) (
	input logic clk,
	input logic resetn,
	input logic go,
	input score_t score,
	input logic obj_wr,
	input logic [$clog2(OBJ_COUNT)-1:0] obj_idx,
	input obj_entry_t obj_data,
	output x_t x,
	output y_t y,
	output color_t color,
	output logic write_en,
	output logic frame_done,
	output level_t level,
	output logic game_over,
	output logic [7:0] time_left
);

	logic over;
	logic run;
	logic restart;
	logic time_up;
	logic [$clog2(OBJ_COUNT)-1:0] rd_idx;
	obj_entry_t rd_data;

	pixel_if bg_pix ();
	pixel_if obj_pix ();

	view_ctrl ctrl_i (
		.clk(clk),
		.resetn(resetn),
		.go(go),
		.score(score),
		.bg(bg_pix.ctrl),
		.obj(obj_pix.ctrl),
		.over(over),
		.time_up(time_up),
		.run(run),
		.restart(restart),
		.x(x),
		.y(y),
		.color(color),
		.write_en(write_en),
		.frame_done(frame_done),
		.level(level),
		.game_over(game_over)
	);

	background_painter #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.GROUND_Y(GROUND_Y)
	) bg_painter_i (
		.clk(clk),
		.resetn(resetn),
		.over(over),
		.pix(bg_pix.painter)
	);

	object_painter #(
		.OBJ_COUNT(OBJ_COUNT),
		.SPRITE_SIZE(SPRITE_SIZE)
	) obj_painter_i (
		.clk(clk),
		.resetn(resetn),
		.pix(obj_pix.painter),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	object_table #(
		.OBJ_COUNT(OBJ_COUNT)
	) obj_table_i (
		.clk(clk),
		.resetn(resetn),
		.wr(obj_wr),
		.wr_idx(obj_idx),
		.wr_data(obj_data),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	round_timer #(
		.TICKS_PER_SEC(TICKS_PER_SEC),
		.ROUND_SECONDS(ROUND_SECONDS)
	) timer_i (
		.clk(clk),
		.resetn(resetn),
		.run(run),
		.restart(restart),
		.time_left(time_left),
		.time_up(time_up)
	);

endmodule

// File: hdl/view_ctrl.sv
/* frame FSM over the two painters, level and goal rule, game-over latch
   and the registered output pixel stream */
`timescale 1ns/10ps

module view_ctrl import game_view_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic go,
	input score_t score,
	pixel_if.ctrl bg,
	pixel_if.ctrl obj,
	output logic over,
	input logic time_up,
	output logic run,
	output logic restart,
	output x_t x,
	output y_t y,
	output color_t color,
	output logic write_en,
	output logic frame_done,
	output level_t level,
	output logic game_over
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BG,
		ST_OBJ,
		ST_FINISH
	} state_t;

	state_t state;
	logic [11:0] goal;
	logic level_up;

	assign goal = GOAL_BASE + GOAL_STEP * {9'd0, level};
	// no step past the top level
	assign level_up = (state == ST_FINISH) && ({2'b00, score} >= goal) && (level < MAX_LEVEL);
	assign restart = level_up;

	assign run = !game_over;
	assign over = game_over;

	// start pulses, each only while its painter is idle
	assign bg.start = (state == ST_IDLE) && go;
	assign obj.start = (state == ST_BG) && bg.done && !game_over;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (go)
						state <= ST_BG;
				end
				ST_BG: begin
					// game-over frame is the fill alone
					if (bg.done)
						state <= game_over ? ST_FINISH : ST_OBJ;
				end
				ST_OBJ: begin
					if (obj.done)
						state <= ST_FINISH;
				end
				ST_FINISH: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			level <= '0;
			game_over <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= (state == ST_FINISH);
			if (level_up)
				level <= level + 1'b1;
			// only between frames, so a frame keeps one look
			if ((state == ST_IDLE) && time_up)
				game_over <= 1'b1;
		end
	end

	// output register, one cycle behind the active painter
	always_ff @(posedge clk) begin
		if (!resetn)
			write_en <= 1'b0;
		else if (state == ST_BG)
			write_en <= bg.write_en;
		else if (state == ST_OBJ)
			write_en <= obj.write_en;
		else
			write_en <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (state == ST_OBJ) begin
			x <= obj.x;
			y <= obj.y;
			color <= obj.color;
		end else begin
			x <= bg.x;
			y <= bg.y;
			color <= bg.color;
		end
	end

endmodule

// File: hdl/round_timer.sv
/* round timer, tick prescaler and whole-second countdown with time-up level */
`timescale 1ns/10ps

module round_timer #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int ROUND_SECONDS = 60
) (
	input logic clk,
	input logic resetn,
	input logic run,
	input logic restart,
	output logic [7:0] time_left,
	output logic time_up
);

	localparam int TICK_W = $clog2(TICKS_PER_SEC);

	logic [TICK_W-1:0] tick_cnt;
	logic sec_tick;

	assign sec_tick = (tick_cnt == TICK_W'(TICKS_PER_SEC - 1));
	assign time_up = (time_left == 8'd0);

	always_ff @(posedge clk) begin
		if (!resetn || restart) begin
			tick_cnt <= '0;
			time_left <= 8'(ROUND_SECONDS);
		end else if (run && !time_up) begin
			if (sec_tick) begin
				tick_cnt <= '0;
				time_left <= time_left - 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

// File: hdl/object_painter.sv
/* object table walker, one lookup cycle per entry and a solid sprite square
   for each visible entry with a kind */
`timescale 1ns/10ps

module object_painter import game_view_pkg::*; #(
	parameter int OBJ_COUNT = 15,
	parameter int SPRITE_SIZE = 20
) (
	input logic clk,
	input logic resetn,
	pixel_if.painter pix,
	output logic [$clog2(OBJ_COUNT)-1:0] rd_idx,
	input obj_entry_t rd_data
);

	localparam int IDX_W = $clog2(OBJ_COUNT);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOK,
		ST_DRAW
	} state_t;

	state_t state;
	logic [IDX_W-1:0] idx;
	obj_entry_t ent;
	x_t dx;
	y_t dy;
	logic last_idx;
	logic drawable;
	logic last_dx;
	logic last_dy;

	assign last_idx = (idx == IDX_W'(OBJ_COUNT - 1));
	assign drawable = rd_data.visible && (rd_data.kind != KIND_NONE);
	assign last_dx = (dx == x_t'(SPRITE_SIZE - 1));
	assign last_dy = (dy == y_t'(SPRITE_SIZE - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			idx <= '0;
			dx <= '0;
			dy <= '0;
			pix.done <= 1'b0;
		end else begin
			pix.done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (pix.start) begin
						idx <= '0;
						state <= ST_LOOK;
					end
				end
				ST_LOOK: begin
					if (drawable) begin
						dx <= '0;
						dy <= '0;
						state <= ST_DRAW;
					end else if (last_idx) begin
						state <= ST_IDLE;
						pix.done <= 1'b1;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				ST_DRAW: begin
					if (!last_dx) begin
						dx <= dx + 1'b1;
					end else begin
						dx <= '0;
						dy <= dy + 1'b1;
						if (last_dy) begin
							// square finished, move on to the next slot
							if (last_idx) begin
								state <= ST_IDLE;
								pix.done <= 1'b1;
							end else begin
								idx <= idx + 1'b1;
								state <= ST_LOOK;
							end
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// entry held for the whole sweep
	always_ff @(posedge clk) begin
		if (state == ST_LOOK)
			ent <= rd_data;
	end

	assign rd_idx = idx;
	assign pix.x = ent.x + dx;
	assign pix.y = ent.y + dy;
	assign pix.write_en = (state == ST_DRAW);

	always_comb begin
		case (ent.kind)
			KIND_GOLD: pix.color = GOLD_COLOR;
			KIND_STONE: pix.color = STONE_COLOR;
			KIND_DIAMOND: pix.color = DIAMOND_COLOR;
			default: pix.color = SKY_COLOR;
		endcase
	end

endmodule

// File: hdl/background_painter.sv
/* full-screen raster sweep, sky above the ground line and earth below,
   or a solid game-over fill */
`timescale 1ns/10ps

module background_painter import game_view_pkg::*; #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int GROUND_Y = 80
) (
	input logic clk,
	input logic resetn,
	input logic over,
	pixel_if.painter pix
);

	logic busy;
	x_t x_cnt;
	y_t y_cnt;
	logic last_col;
	logic last_row;

	assign last_col = (x_cnt == x_t'(SCREEN_W - 1));
	assign last_row = (y_cnt == y_t'(SCREEN_H - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			x_cnt <= '0;
			y_cnt <= '0;
			pix.done <= 1'b0;
		end else begin
			pix.done <= 1'b0;
			if (!busy) begin
				if (pix.start) begin
					busy <= 1'b1;
					x_cnt <= '0;
					y_cnt <= '0;
				end
			end else if (last_col) begin
				x_cnt <= '0;
				if (last_row) begin
					// last pixel of the screen
					busy <= 1'b0;
					pix.done <= 1'b1;
				end else begin
					y_cnt <= y_cnt + 1'b1;
				end
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

	assign pix.x = x_cnt;
	assign pix.y = y_cnt;
	assign pix.write_en = busy;

	always_comb begin
		if (over)
			pix.color = OVER_COLOR;
		else if (y_cnt < y_t'(GROUND_Y))
			pix.color = SKY_COLOR;
		else
			pix.color = EARTH_COLOR;
	end

endmodule

// File: hdl/object_table.sv
/* object table register array, one write port and one combinational read port */
`timescale 1ns/10ps

module object_table import game_view_pkg::*; #(
	parameter int OBJ_COUNT = 15
) (
	input logic clk,
	input logic resetn,
	input logic wr,
	input logic [$clog2(OBJ_COUNT)-1:0] wr_idx,
	input obj_entry_t wr_data,
	input logic [$clog2(OBJ_COUNT)-1:0] rd_idx,
	output obj_entry_t rd_data
);

	obj_entry_t entries [OBJ_COUNT];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			// every slot comes up empty and hidden
			for (int i = 0; i < OBJ_COUNT; i++) begin
				entries[i] <= '0;
			end
		end else if (wr && (int'(wr_idx) < OBJ_COUNT)) begin
			entries[wr_idx] <= wr_data;
		end
	end

	assign rd_data = entries[rd_idx];

endmodule

// File: hdl/pixel_if.sv
/* pixel stream from one painter to the view controller, with start/done */
`timescale 1ns/10ps

interface pixel_if import game_view_pkg::*; ();

	logic start;
	x_t x;
	y_t y;
	color_t color;
	logic write_en;
	logic done;

	// painter side
	modport painter (
		input start,
		output x, y, color, write_en, done
	);

	// controller side
	modport ctrl (
		output start,
		input x, y, color, write_en, done
	);

endinterface

// File: hdl/game_view_pkg.sv
/* shared types and constants for the game view:
   screen coordinates, colors, object entries, level and goal values */
package game_view_pkg;

	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;
	typedef logic [11:0] color_t;
	typedef logic [2:0] level_t;
	typedef logic [9:0] score_t;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_GOLD,
		KIND_STONE,
		KIND_DIAMOND
	} obj_kind_t;

	// one object table slot, 20 bits
	typedef struct packed {
		x_t x;
		y_t y;
		obj_kind_t kind;
		logic visible;
	} obj_entry_t;

	// RGB444, none of them zero
	localparam color_t SKY_COLOR = 12'h6CF;
	localparam color_t EARTH_COLOR = 12'h852;
	localparam color_t GOLD_COLOR = 12'hFD0;
	localparam color_t STONE_COLOR = 12'h888;
	localparam color_t DIAMOND_COLOR = 12'h0EF;
	localparam color_t OVER_COLOR = 12'hF00;

	// goal of a level is GOAL_BASE + GOAL_STEP * level
	localparam logic [11:0] GOAL_BASE = 12'd75;
	localparam logic [11:0] GOAL_STEP = 12'd75;
	localparam level_t MAX_LEVEL = 3'd7;

endpackage
